/* logic/accel_cfg_pkg.sv */
package accel_cfg_pkg;

  // datapath sizing
  localparam int LANES       = 4;
  localparam int WORD_WIDTH  = 8;
  localparam int ACC_WIDTH   = 20;
  localparam int KERNEL_LEN  = 3;

  // leaky relu slope of 1/8 on negative sums
  localparam int LRELU_SHIFT = 3;
  localparam int signed ACT_MAX = 2 ** (WORD_WIDTH - 1) - 1;
  localparam int signed ACT_MIN = -(2 ** (WORD_WIDTH - 1));

  // flow control, fifo depth doubles as host input credits
  localparam int IN_CREDITS  = 4;
  localparam int OUT_CREDITS = 2;

  // derived widths
  localparam int TAP_W     = $clog2(KERNEL_LEN);
  localparam int IN_PTR_W  = $clog2(IN_CREDITS);
  localparam int IN_CNT_W  = $clog2(IN_CREDITS + 1);
  localparam int OUT_CNT_W = $clog2(OUT_CREDITS + 1);

endpackage

/* logic/accel_types_pkg.sv */
package accel_types_pkg;

  typedef logic signed [accel_cfg_pkg::WORD_WIDTH-1:0] word_t;
  typedef logic signed [accel_cfg_pkg::ACC_WIDTH-1:0]  acc_t;

  typedef enum logic {
    OP_WEIGHTS = 1'b0,
    OP_PIXELS  = 1'b1
  } op_e;

  // host beat, weight beats use lanes 0..KERNEL_LEN-1 as taps
  typedef struct packed {
    op_e                               op;
    word_t [accel_cfg_pkg::LANES-1:0]  lane;
  } in_beat_t;

  typedef struct packed {
    word_t [accel_cfg_pkg::LANES-1:0] lane;
  } pixel_beat_t;

  typedef struct packed {
    word_t [accel_cfg_pkg::KERNEL_LEN-1:0] tap;
  } weight_set_t;

  typedef struct packed {
    acc_t [accel_cfg_pkg::LANES-1:0] lane;
  } acc_beat_t;

  typedef struct packed {
    word_t [accel_cfg_pkg::LANES-1:0] lane;
  } act_beat_t;

  typedef enum logic {CONV_IDLE, CONV_ACCUM} conv_state_e;

  typedef enum logic {POOL_FIRST, POOL_SECOND} pool_state_e;

endpackage

/* logic/input_pipe.sv */
module input_pipe (
  input  logic                        aclk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  input  accel_types_pkg::in_beat_t   in_beat,
  output logic                        in_credit,
  output logic                        px_valid,
  output accel_types_pkg::pixel_beat_t px,
  output accel_types_pkg::weight_set_t weights,
  input  logic                        px_take
);

  accel_types_pkg::in_beat_t mem [accel_cfg_pkg::IN_CREDITS];

  logic [accel_cfg_pkg::IN_PTR_W-1:0] wr_ptr;
  logic [accel_cfg_pkg::IN_PTR_W-1:0] rd_ptr;
  logic [accel_cfg_pkg::IN_CNT_W-1:0] count;
  logic                               full;
  logic                               empty;
  logic                               head_is_weight;
  logic                               pop;
  accel_types_pkg::in_beat_t          head;
  accel_types_pkg::weight_set_t       weights_q;

  assign full  = count == accel_cfg_pkg::IN_CNT_W'(accel_cfg_pkg::IN_CREDITS);
  assign empty = count == '0;
  assign head  = mem[rd_ptr];

  // weight beats leave the fifo on their own
  assign head_is_weight = !empty && head.op == accel_types_pkg::OP_WEIGHTS;
  assign px_valid       = !empty && head.op == accel_types_pkg::OP_PIXELS;
  assign px.lane        = head.lane;
  assign pop            = head_is_weight || px_take;
  assign in_credit      = pop; // one credit back per popped entry
  assign weights        = weights_q;

  always_ff @(posedge aclk) begin
    if (in_valid) mem[wr_ptr] <= in_beat;
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      weights_q <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == accel_cfg_pkg::IN_PTR_W'(accel_cfg_pkg::IN_CREDITS - 1)) ?
                  '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == accel_cfg_pkg::IN_PTR_W'(accel_cfg_pkg::IN_CREDITS - 1)) ?
                  '0 : rd_ptr + 1'b1;
      end
      case ({in_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (head_is_weight) weights_q.tap <= head.lane[accel_cfg_pkg::KERNEL_LEN-1:0]; // lane 3 dropped
    end
  end

  // host sent a beat without holding a credit
  a_no_overrun: assert property (@(posedge aclk) disable iff (!rst_n) in_valid |-> !full)
    else $error("input fifo overrun");

  a_take_valid: assert property (@(posedge aclk) disable iff (!rst_n) px_take |-> px_valid)
    else $error("px_take without px_valid");

endmodule

/* logic/conv_engine.sv */
module conv_engine (
  input  logic                         aclk,
  input  logic                         rst_n,
  input  logic                         px_valid,
  input  accel_types_pkg::pixel_beat_t px,
  input  accel_types_pkg::weight_set_t weights,
  output logic                         px_take,
  input  logic                         out_credit,
  output logic                         acc_valid,
  output accel_types_pkg::acc_beat_t   acc
);

  accel_types_pkg::conv_state_e        state_q;
  logic [accel_cfg_pkg::TAP_W-1:0]     tap_q;
  logic                                pair_q;   // 0 first window, 1 second
  logic [accel_cfg_pkg::OUT_CNT_W-1:0] cnt_q;
  logic                                can_go;
  logic                                last_tap;
  logic                                spend;
  logic                                acc_valid_q;
  accel_types_pkg::word_t              w_cur;
  accel_types_pkg::acc_beat_t          acc_q;

  // mid-pair or a credit left for a new pair
  assign can_go   = state_q == accel_types_pkg::CONV_ACCUM || pair_q || cnt_q != '0;
  assign px_take  = px_valid && can_go;
  assign last_tap = tap_q == accel_cfg_pkg::TAP_W'(accel_cfg_pkg::KERNEL_LEN - 1);
  assign spend    = px_take && state_q == accel_types_pkg::CONV_IDLE && !pair_q;
  assign w_cur    = weights.tap[tap_q];

  assign acc_valid = acc_valid_q;
  assign acc       = acc_q;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state_q     <= accel_types_pkg::CONV_IDLE;
      tap_q       <= '0;
      pair_q      <= 1'b0;
      cnt_q       <= accel_cfg_pkg::OUT_CNT_W'(accel_cfg_pkg::OUT_CREDITS);
      acc_valid_q <= 1'b0;
    end else begin
      acc_valid_q <= px_take && last_tap;
      if (px_take) begin
        if (last_tap) begin
          tap_q   <= '0;
          state_q <= accel_types_pkg::CONV_IDLE;
          pair_q  <= !pair_q;
        end else begin
          tap_q   <= tap_q + 1'b1;
          state_q <= accel_types_pkg::CONV_ACCUM;
        end
      end
      case ({out_credit, spend})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (px_take) begin
      for (int i = 0; i < accel_cfg_pkg::LANES; i++) begin
        if (state_q == accel_types_pkg::CONV_IDLE)
          acc_q.lane[i] <= px.lane[i] * w_cur; // first tap restarts the sum
        else
          acc_q.lane[i] <= acc_q.lane[i] + px.lane[i] * w_cur;
      end
    end
  end

  a_cnt_bound: assert property (@(posedge aclk) disable iff (!rst_n)
    cnt_q <= accel_cfg_pkg::OUT_CREDITS) else $error("output credit count above limit");

  // host returned more credits than it was given
  a_no_extra_credit: assert property (@(posedge aclk) disable iff (!rst_n)
    (out_credit && !spend) |-> cnt_q < accel_cfg_pkg::OUT_CREDITS)
    else $error("out_credit with all credits home");

endmodule

/* logic/lrelu_engine.sv */
module lrelu_engine (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic                       acc_valid,
  input  accel_types_pkg::acc_beat_t acc,
  output logic                       act_valid,
  output accel_types_pkg::act_beat_t act
);

  accel_types_pkg::act_beat_t act_d;
  accel_types_pkg::act_beat_t act_q;
  logic                       act_valid_q;

  always_comb begin
    accel_types_pkg::acc_t v;
    for (int i = 0; i < accel_cfg_pkg::LANES; i++) begin
      // arithmetic shift floors toward minus infinity
      v = acc.lane[i] < 0 ? acc.lane[i] >>> accel_cfg_pkg::LRELU_SHIFT : acc.lane[i];
      if (v > accel_cfg_pkg::ACT_MAX)      act_d.lane[i] = accel_types_pkg::word_t'(accel_cfg_pkg::ACT_MAX);
      else if (v < accel_cfg_pkg::ACT_MIN) act_d.lane[i] = accel_types_pkg::word_t'(accel_cfg_pkg::ACT_MIN);
      else                                 act_d.lane[i] = accel_types_pkg::word_t'(v);
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) act_valid_q <= 1'b0;
    else        act_valid_q <= acc_valid;
  end

  always_ff @(posedge aclk) begin
    if (acc_valid) act_q <= act_d;
  end

  assign act_valid = act_valid_q;
  assign act       = act_q;

endmodule

/* logic/maxpool_engine.sv */
module maxpool_engine (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic                       act_valid,
  input  accel_types_pkg::act_beat_t act,
  output logic                       out_valid,
  output accel_types_pkg::act_beat_t out_beat
);

  accel_types_pkg::pool_state_e state_q;
  accel_types_pkg::act_beat_t   hold_q;   // first activation of the pair
  accel_types_pkg::act_beat_t   max_d;
  accel_types_pkg::act_beat_t   out_q;
  logic                         out_valid_q;

  always_comb begin
    for (int i = 0; i < accel_cfg_pkg::LANES; i++) begin
      max_d.lane[i] = (act.lane[i] > hold_q.lane[i]) ? act.lane[i] : hold_q.lane[i];
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state_q     <= accel_types_pkg::POOL_FIRST;
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= act_valid && state_q == accel_types_pkg::POOL_SECOND;
      if (act_valid) begin
        state_q <= (state_q == accel_types_pkg::POOL_FIRST) ?
                   accel_types_pkg::POOL_SECOND : accel_types_pkg::POOL_FIRST;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (act_valid) begin
      if (state_q == accel_types_pkg::POOL_FIRST)
        hold_q <= act;
      else
        out_q <= max_d;
    end
  end

  assign out_valid = out_valid_q;
  assign out_beat  = out_q;

  // pooled outputs at least two windows apart
  a_out_gap: assert property (@(posedge aclk) disable iff (!rst_n)
    out_valid |=> !out_valid [* (2 * accel_cfg_pkg::KERNEL_LEN - 1)])
    else $error("out_valid closer than two windows");

endmodule

/* logic/accel_top.sv */
module accel_top (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  accel_types_pkg::in_beat_t  in_beat,
  output logic                       in_credit,
  output logic                       out_valid,
  output accel_types_pkg::act_beat_t out_beat,
  input  logic                       out_credit
);

  logic                         px_valid;
  logic                         px_take;
  accel_types_pkg::pixel_beat_t px;
  accel_types_pkg::weight_set_t weights;
  logic                         acc_valid;
  accel_types_pkg::acc_beat_t   acc;
  logic                         act_valid;
  accel_types_pkg::act_beat_t   act;

  input_pipe input_pipe_i (
    .aclk      (aclk     ),
    .rst_n     (rst_n    ),
    .in_valid  (in_valid ),
    .in_beat   (in_beat  ),
    .in_credit (in_credit),
    .px_valid  (px_valid ),
    .px        (px       ),
    .weights   (weights  ),
    .px_take   (px_take  )
  );

  // owns the output credits
  conv_engine conv_engine_i (
    .aclk       (aclk      ),
    .rst_n      (rst_n     ),
    .px_valid   (px_valid  ),
    .px         (px        ),
    .weights    (weights   ),
    .px_take    (px_take   ),
    .out_credit (out_credit),
    .acc_valid  (acc_valid ),
    .acc        (acc       )
  );

  lrelu_engine lrelu_engine_i (
    .aclk      (aclk     ),
    .rst_n     (rst_n    ),
    .acc_valid (acc_valid),
    .acc       (acc      ),
    .act_valid (act_valid),
    .act       (act      )
  );

  maxpool_engine maxpool_engine_i (
    .aclk      (aclk     ),
    .rst_n     (rst_n    ),
    .act_valid (act_valid),
    .act       (act      ),
    .out_valid (out_valid),
    .out_beat  (out_beat )
  );

endmodule

/* tests/tb_clock.sv */
module tb_clock (
  output logic aclk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 5;

  initial begin
    aclk = 1'b0;
    forever #HALF_PERIOD aclk = ~aclk;
  end

  // held low for four rising edges
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge aclk);
    #1 rst_n = 1'b1;
  end

endmodule

/* tests/tb_accel.sv */
module tb_accel;

  localparam int CLK_PERIOD = 10;
  // reset 4, single 7, lrelu 7, reload 14, back-pressure 30, random up to 85
  localparam int MAX_BEATS  = 147;
  localparam int WATCHDOG_CYCLES = MAX_BEATS * 40 + 200;

  logic                       aclk;
  logic                       rst_n;
  logic                       in_valid = 1'b0;
  accel_types_pkg::in_beat_t  in_beat = '0;
  logic                       in_credit;
  logic                       out_valid;
  accel_types_pkg::act_beat_t out_beat;
  logic                       out_credit = 1'b0;

  accel_types_pkg::in_beat_t    send_q [$];
  accel_types_pkg::act_beat_t   exp_q [$];
  accel_types_pkg::pixel_beat_t pix [6];
  int          model_w [accel_cfg_pkg::KERNEL_LEN];
  int          beats_sent = 0;
  int          in_credits_back = 0;
  int          outs_seen = 0;
  int          out_credits_back = 0;
  int          errors = 0;
  bit          credit_en = 1'b1;
  int          max_gap = 0;
  int          gap = 0;
  int unsigned lcg_state = 94542;

  tb_clock tb_clock_i (.aclk(aclk), .rst_n(rst_n));

  accel_top accel_top_i (
    .aclk       (aclk      ),
    .rst_n      (rst_n     ),
    .in_valid   (in_valid  ),
    .in_beat    (in_beat   ),
    .in_credit  (in_credit ),
    .out_valid  (out_valid ),
    .out_beat   (out_beat  ),
    .out_credit (out_credit)
  );

  task automatic fail_now(string msg);
    errors++;
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_act(string name, accel_types_pkg::act_beat_t exp,
                           accel_types_pkg::act_beat_t got);
    if (got !== exp)
      fail_now($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
  endtask

  task automatic check_count(string name, int exp, int got);
    if (got != exp)
      fail_now($sformatf("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got));
  endtask

  function automatic int bit_val(logic b);
    return $isunknown(b) ? -1 : int'(b);
  endfunction

  function automatic int lcg_next();
    lcg_state = lcg_state * 1103515245 + 12345;
    return int'((lcg_state >> 16) & 32'h7fff);
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + lcg_next() % (hi - lo + 1);
  endfunction

  function automatic accel_types_pkg::pixel_beat_t make_px(int a, int b, int c, int d);
    accel_types_pkg::pixel_beat_t p;
    p.lane[0] = accel_types_pkg::word_t'(a);
    p.lane[1] = accel_types_pkg::word_t'(b);
    p.lane[2] = accel_types_pkg::word_t'(c);
    p.lane[3] = accel_types_pkg::word_t'(d);
    return p;
  endfunction

  // dot product, leaky slope with floor, then clamp to a pixel word
  function automatic accel_types_pkg::act_beat_t window_act(
    accel_types_pkg::pixel_beat_t p0, accel_types_pkg::pixel_beat_t p1,
    accel_types_pkg::pixel_beat_t p2);
    accel_types_pkg::act_beat_t r;
    int s;
    int div;
    div = 2 ** accel_cfg_pkg::LRELU_SHIFT;
    for (int i = 0; i < accel_cfg_pkg::LANES; i++) begin
      s = p0.lane[i] * model_w[0] + p1.lane[i] * model_w[1] + p2.lane[i] * model_w[2];
      if (s < 0) s = -((-s + div - 1) / div);
      if (s > accel_cfg_pkg::ACT_MAX) s = accel_cfg_pkg::ACT_MAX;
      if (s < accel_cfg_pkg::ACT_MIN) s = accel_cfg_pkg::ACT_MIN;
      r.lane[i] = accel_types_pkg::word_t'(s);
    end
    return r;
  endfunction

  task automatic load_weights(int w0, int w1, int w2);
    accel_types_pkg::in_beat_t b;
    b.op      = accel_types_pkg::OP_WEIGHTS;
    b.lane[0] = accel_types_pkg::word_t'(w0);
    b.lane[1] = accel_types_pkg::word_t'(w1);
    b.lane[2] = accel_types_pkg::word_t'(w2);
    b.lane[3] = accel_types_pkg::word_t'(rand_range(-128, 127)); // unused lane
    model_w = '{w0, w1, w2};
    send_q.push_back(b);
  endtask

  task automatic fill_random(int lo, int hi);
    for (int k = 0; k < 6; k++)
      pix[k] = make_px(rand_range(lo, hi), rand_range(lo, hi), rand_range(lo, hi),
                       rand_range(lo, hi));
  endtask

  task automatic send_pair();
    accel_types_pkg::in_beat_t  b;
    accel_types_pkg::act_beat_t a0;
    accel_types_pkg::act_beat_t a1;
    accel_types_pkg::act_beat_t pooled;
    for (int k = 0; k < 6; k++) begin
      b.op   = accel_types_pkg::OP_PIXELS;
      b.lane = pix[k].lane;
      send_q.push_back(b);
    end
    a0 = window_act(pix[0], pix[1], pix[2]);
    a1 = window_act(pix[3], pix[4], pix[5]);
    for (int i = 0; i < accel_cfg_pkg::LANES; i++)
      pooled.lane[i] = (a0.lane[i] > a1.lane[i]) ? a0.lane[i] : a1.lane[i];
    exp_q.push_back(pooled);
  endtask

  task automatic wait_idle();
    int n = 0;
    while (send_q.size() != 0 || exp_q.size() != 0 || outs_seen != out_credits_back) begin
      @(posedge aclk);
      n++;
      if (n > 2000) fail_now("timed out waiting for the pipeline to drain");
    end
    repeat (2) @(posedge aclk);
  endtask

  task automatic wait_outputs(int total);
    int n = 0;
    while (outs_seen < total) begin
      @(posedge aclk);
      n++;
      if (n > 1000) fail_now("timed out waiting for pooled outputs");
    end
  endtask

  // host transmit, one beat per cycle while credits last
  always @(posedge aclk) begin
    #1;
    if (rst_n && send_q.size() > 0 &&
        beats_sent - in_credits_back < accel_cfg_pkg::IN_CREDITS) begin
      in_beat  = send_q.pop_front();
      in_valid = 1'b1;
      beats_sent++;
    end else begin
      in_valid = 1'b0;
    end
  end

  always @(posedge aclk) begin
    if (in_credit === 1'b1) begin
      in_credits_back++;
      if (in_credits_back > beats_sent) fail_now("more input credits returned than beats sent");
    end
    if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) fail_now("out_valid while no output was expected");
      else check_act("out_beat", exp_q.pop_front(), out_beat);
      outs_seen++;
    end
  end

  // output slots freed by the host after a random gap
  always @(posedge aclk) begin
    #1;
    if (out_credit) begin
      out_credit = 1'b0;
    end else if (gap > 0) begin
      gap--;
    end else if (credit_en && outs_seen > out_credits_back) begin
      out_credit = 1'b1;
      out_credits_back++;
      gap = (max_gap > 0) ? rand_range(0, max_gap) : 0;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_now("watchdog expired before the tests finished");
  end

  task automatic test_reset();
    @(posedge aclk);
    while (!rst_n) begin
      @(negedge aclk);
      check_count("out_valid", 0, bit_val(out_valid));
      check_count("in_credit", 0, bit_val(in_credit));
    end
    repeat (3) begin
      @(negedge aclk);
      check_count("out_valid", 0, bit_val(out_valid));
      check_count("in_credit", 0, bit_val(in_credit));
    end
    for (int n = 0; n < accel_cfg_pkg::IN_CREDITS; n++)
      load_weights(rand_range(-5, 5), rand_range(-5, 5), rand_range(-5, 5));
    wait_idle();
    check_count("in_credit pulses", accel_cfg_pkg::IN_CREDITS, in_credits_back);
  endtask

  task automatic test_single_pool();
    int base = outs_seen;
    load_weights(1, 2, 3);
    fill_random(0, 9);
    send_pair();
    wait_idle();
    check_count("pooled outputs", base + 1, outs_seen);
  endtask

  task automatic test_lrelu_saturate();
    load_weights(10, 10, 10);
    // lanes: saturate high, moderate negative, clamp low, small negative
    for (int k = 0; k < 3; k++) pix[k] = make_px(100, -3, -100, -1);
    for (int k = 3; k < 6; k++) pix[k] = make_px(90, -5, -120, -2);
    send_pair();
    wait_idle();
  endtask

  task automatic test_weight_reload();
    load_weights(1, -1, 2);
    fill_random(-20, 20);
    send_pair();
    load_weights(-2, 3, 1);
    fill_random(-20, 20);
    send_pair();
    wait_idle();
  endtask

  task automatic test_backpressure();
    int base = outs_seen;
    credit_en = 1'b0;
    for (int n = 0; n < 5; n++) begin
      fill_random(-30, 30);
      send_pair();
    end
    wait_outputs(base + accel_cfg_pkg::OUT_CREDITS);
    repeat (50) @(posedge aclk);
    check_count("outputs under back-pressure", base + accel_cfg_pkg::OUT_CREDITS, outs_seen);
    check_count("beats held in the FIFO", accel_cfg_pkg::IN_CREDITS,
                beats_sent - in_credits_back);
    max_gap   = 3;
    credit_en = 1'b1;
    wait_idle();
    check_count("outputs after release", base + 5, outs_seen);
    check_count("total in_credit pulses", beats_sent, in_credits_back);
    max_gap = 0;
  endtask

  task automatic test_random_stream();
    max_gap = 5;
    load_weights(rand_range(-20, 20), rand_range(-20, 20), rand_range(-20, 20));
    for (int n = 0; n < 12; n++) begin
      if (rand_range(0, 2) == 0)
        load_weights(rand_range(-20, 20), rand_range(-20, 20), rand_range(-20, 20));
      fill_random(-64, 63);
      send_pair();
    end
    wait_idle();
    max_gap = 0;
  endtask

  initial begin
    test_reset();
    test_single_pool();
    test_lrelu_saturate();
    test_weight_reload();
    test_backpressure();
    test_random_stream();
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* tb.f */
logic/accel_cfg_pkg.sv
logic/accel_types_pkg.sv
logic/input_pipe.sv
logic/conv_engine.sv
logic/lrelu_engine.sv
logic/maxpool_engine.sv
logic/accel_top.sv
tests/tb_clock.sv
tests/tb_accel.sv

/* Bender.yml */
package:
  name: conv_accel

sources:
  - logic/accel_cfg_pkg.sv
  - logic/accel_types_pkg.sv
  - logic/input_pipe.sv
  - logic/conv_engine.sv
  - logic/lrelu_engine.sv
  - logic/maxpool_engine.sv
  - logic/accel_top.sv
  - target: simulation
    files:
      - tests/tb_clock.sv
      - tests/tb_accel.sv
